//--- design/conv_cell.sv
`timescale 1ns/1ns
`include "net_engine_cfg.svh"

module conv_cell (
	input logic S_AXIS_ACLK,
	input logic S_AXIS_ARESETN,
	input net_engine_pkg::window_t win,
	input logic win_valid,
	input logic win_last,
	input net_engine_pkg::engine_cfg_t cfg,
	output net_engine_pkg::result_t res,
	output logic res_valid
);
	import net_engine_pkg::*;

	pixel_t prod [`NE_KERNEL_TAPS];
	logic prod_valid;
	logic prod_last;
	pixel_t acc;

	// Stage one, products kept to the low 32 bits
	always_ff @(posedge S_AXIS_ACLK) begin
		for (int i = 0; i < `NE_KERNEL_TAPS; i++)
			prod[i] <= pixel_t'(win.tap[i] * cfg.weight[i]);
		prod_last <= win_last;
	end

	// Sum of products plus bias, wraps modulo 2^32
	always_comb begin
		acc = cfg.bias;
		for (int i = 0; i < `NE_KERNEL_TAPS; i++)
			acc = acc + prod[i];
	end

	// Stage two
	always_ff @(posedge S_AXIS_ACLK) begin
		res.value <= acc;
		res.last <= prod_last;
	end

	always_ff @(posedge S_AXIS_ACLK) begin
		if (!S_AXIS_ARESETN) begin
			prod_valid <= 1'b0;
			res_valid <= 1'b0;
		end else begin
			prod_valid <= win_valid;
			res_valid <= prod_valid;
		end
	end

endmodule

//--- design/maxpool_cell.sv
`timescale 1ns/1ns

module maxpool_cell (
	input logic S_AXIS_ACLK,
	input logic S_AXIS_ARESETN,
	input net_engine_pkg::window_t win,
	input logic win_valid,
	input logic win_last,
	output net_engine_pkg::result_t res,
	output logic res_valid
);
	import net_engine_pkg::*;

	pixel_t row_max [3];
	logic row_valid;
	logic row_last;

	// Signed compare of two pixels
	function automatic pixel_t max2(input pixel_t a, input pixel_t b);
		return (a > b) ? a : b;
	endfunction

	// Stage one, maximum within each row
	always_ff @(posedge S_AXIS_ACLK) begin
		for (int r = 0; r < 3; r++)
			row_max[r] <= max2(max2(win.tap[r * 3], win.tap[r * 3 + 1]), win.tap[r * 3 + 2]);
		row_last <= win_last;
	end

	// Stage two, across the rows
	always_ff @(posedge S_AXIS_ACLK) begin
		res.value <= max2(max2(row_max[0], row_max[1]), row_max[2]);
		res.last <= row_last;
	end

	always_ff @(posedge S_AXIS_ACLK) begin
		if (!S_AXIS_ARESETN) begin
			row_valid <= 1'b0;
			res_valid <= 1'b0;
		end else begin
			row_valid <= win_valid;
			res_valid <= row_valid;
		end
	end

endmodule

//--- design/net_engine_cfg.svh
`ifndef NET_ENGINE_CFG_SVH
`define NET_ENGINE_CFG_SVH

// Pixel, weight and result width
`define NE_DATA_WIDTH 32

// Pixels per image row
`define NE_ROW_WORDS 8

// 3x3 window
`define NE_KERNEL_TAPS 9

// Room for two whole passes of results
`define NE_FIFO_DEPTH (2 * (`NE_ROW_WORDS - 2))

`endif

//--- design/net_engine_pkg.sv
`include "net_engine_cfg.svh"

package net_engine_pkg;

	// One signed pixel or coefficient
	typedef logic signed [`NE_DATA_WIDTH-1:0] pixel_t;

	// 3x3 window, row by row, top-left in tap[0]
	typedef struct packed {
		pixel_t [0:`NE_KERNEL_TAPS-1] tap;
	} window_t;

	// Static engine setup, held stable while passes run
	typedef struct packed {
		pixel_t [0:`NE_KERNEL_TAPS-1] weight; // Same order as window_t
		pixel_t bias;
		logic mode; // 1 selects convolution, 0 max-pool
	} engine_cfg_t;

	// Cell output word with its end-of-pass marker
	typedef struct packed {
		pixel_t value;
		logic last;
	} result_t;

endpackage

//--- design/net_engine_top.sv
`timescale 1ns/1ns
`include "net_engine_cfg.svh"

module net_engine_top (
	input logic S_AXIS_ACLK,
	input logic S_AXIS_ARESETN,
	input net_engine_pkg::pixel_t s_axis_tdata,
	input logic s_axis_tvalid,
	output logic s_axis_tready,
	output net_engine_pkg::pixel_t m_axis_tdata,
	output logic m_axis_tvalid,
	input logic m_axis_tready,
	output logic m_axis_tlast,
	input net_engine_pkg::engine_cfg_t cfg
);
	import net_engine_pkg::*;

	logic row_done;
	logic rows_ready;
	logic busy;
	logic credit_ok;

	// Window read port
	logic rd_en;
	logic [$clog2(`NE_ROW_WORDS)-1:0] rd_col;
	logic rd_last;
	window_t win;
	logic win_valid;
	logic win_last;

	// Cell results, both computed for every window
	result_t conv_res;
	logic conv_valid;
	result_t pool_res;
	logic pool_valid;

	row_buffer_bank u_rows (
		.S_AXIS_ACLK(S_AXIS_ACLK), .S_AXIS_ARESETN(S_AXIS_ARESETN),
		.s_axis_tdata(s_axis_tdata), .s_axis_tvalid(s_axis_tvalid),
		.s_axis_tready(s_axis_tready), .busy(busy),
		.row_done(row_done), .rows_ready(rows_ready),
		.rd_en(rd_en), .rd_col(rd_col), .rd_last(rd_last),
		.win(win), .win_valid(win_valid), .win_last(win_last)
	);

	window_sequencer u_seq (
		.S_AXIS_ACLK(S_AXIS_ACLK), .S_AXIS_ARESETN(S_AXIS_ARESETN),
		.row_done(row_done), .rows_ready(rows_ready), .credit_ok(credit_ok),
		.busy(busy), .rd_en(rd_en), .rd_col(rd_col), .rd_last(rd_last)
	);

	conv_cell u_conv (
		.S_AXIS_ACLK(S_AXIS_ACLK), .S_AXIS_ARESETN(S_AXIS_ARESETN),
		.win(win), .win_valid(win_valid), .win_last(win_last), .cfg(cfg),
		.res(conv_res), .res_valid(conv_valid)
	);

	maxpool_cell u_pool (
		.S_AXIS_ACLK(S_AXIS_ACLK), .S_AXIS_ARESETN(S_AXIS_ARESETN),
		.win(win), .win_valid(win_valid), .win_last(win_last),
		.res(pool_res), .res_valid(pool_valid)
	);

	stream_source u_src (
		.S_AXIS_ACLK(S_AXIS_ACLK), .S_AXIS_ARESETN(S_AXIS_ARESETN),
		.conv_res(conv_res), .conv_valid(conv_valid),
		.pool_res(pool_res), .pool_valid(pool_valid),
		.mode(cfg.mode), .rd_en(rd_en), .credit_ok(credit_ok),
		.m_axis_tdata(m_axis_tdata), .m_axis_tvalid(m_axis_tvalid),
		.m_axis_tready(m_axis_tready), .m_axis_tlast(m_axis_tlast)
	);

endmodule

//--- design/row_buffer_bank.sv
`timescale 1ns/1ns
`include "net_engine_cfg.svh"

module row_buffer_bank (
	input logic S_AXIS_ACLK,
	input logic S_AXIS_ARESETN,
	input net_engine_pkg::pixel_t s_axis_tdata,
	input logic s_axis_tvalid,
	output logic s_axis_tready,
	input logic busy,
	output logic row_done,
	output logic rows_ready,
	input logic rd_en,
	input logic [$clog2(`NE_ROW_WORDS)-1:0] rd_col,
	input logic rd_last,
	output net_engine_pkg::window_t win,
	output logic win_valid,
	output logic win_last
);
	import net_engine_pkg::*;

	localparam int COL_W = $clog2(`NE_ROW_WORDS);

	// Four rotating rows, one being filled while three are read
	pixel_t mem [4][`NE_ROW_WORDS];

	logic [1:0] wr_buf;
	logic [COL_W-1:0] wr_col;
	logic [1:0] rows_stored; // Saturates at 3
	logic wr_fire;
	logic [1:0] rd_buf [3];

	// Input stalls while a pass is pending or running
	assign s_axis_tready = !busy;
	assign wr_fire = s_axis_tvalid && s_axis_tready;
	assign rows_ready = (rows_stored == 2'd3);

	always_ff @(posedge S_AXIS_ACLK) begin
		if (wr_fire)
			mem[wr_buf][wr_col] <= s_axis_tdata;
	end

	always_ff @(posedge S_AXIS_ACLK) begin
		if (!S_AXIS_ARESETN) begin
			wr_buf <= '0;
			wr_col <= '0;
			rows_stored <= '0;
			row_done <= 1'b0;
		end else begin
			row_done <= 1'b0;
			if (wr_fire) begin
				if (wr_col == COL_W'(`NE_ROW_WORDS - 1)) begin
					// Row complete, move on to the next buffer
					wr_col <= '0;
					wr_buf <= wr_buf + 2'd1;
					row_done <= 1'b1;
					if (rows_stored != 2'd3)
						rows_stored <= rows_stored + 2'd1;
				end else begin
					wr_col <= wr_col + 1'b1;
				end
			end
		end
	end

	// Three rows behind the write buffer, oldest first
	always_comb begin
		for (int r = 0; r < 3; r++)
			rd_buf[r] = wr_buf + 2'(r + 1);
	end

	always_ff @(posedge S_AXIS_ACLK) begin
		if (rd_en) begin
			for (int r = 0; r < 3; r++) begin
				for (int c = 0; c < 3; c++)
					win.tap[r * 3 + c] <= mem[rd_buf[r]][rd_col + COL_W'(c)];
			end
		end
	end

	always_ff @(posedge S_AXIS_ACLK) begin
		if (!S_AXIS_ARESETN) begin
			win_valid <= 1'b0;
			win_last <= 1'b0;
		end else begin
			win_valid <= rd_en;
			win_last <= rd_en && rd_last; // Final column of the pass
		end
	end

endmodule

//--- design/stream_source.sv
`timescale 1ns/1ns
`include "net_engine_cfg.svh"

module stream_source (
	input logic S_AXIS_ACLK,
	input logic S_AXIS_ARESETN,
	input net_engine_pkg::result_t conv_res,
	input logic conv_valid,
	input net_engine_pkg::result_t pool_res,
	input logic pool_valid,
	input logic mode,
	input logic rd_en,
	output logic credit_ok,
	output net_engine_pkg::pixel_t m_axis_tdata,
	output logic m_axis_tvalid,
	input logic m_axis_tready,
	output logic m_axis_tlast
);
	import net_engine_pkg::*;

	localparam int PTR_W = $clog2(`NE_FIFO_DEPTH);
	localparam int CNT_W = $clog2(`NE_FIFO_DEPTH + 1);
	localparam int PASS_LEN = `NE_ROW_WORDS - 2;

	result_t fifo_mem [`NE_FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] occupied;
	logic [CNT_W-1:0] reserved; // Occupied plus results still in the pipeline
	result_t push_res;
	logic push;
	logic pop;

	// Depth is not a power of two
	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(`NE_FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign push_res = mode ? conv_res : pool_res;
	assign push = mode ? conv_valid : pool_valid;
	assign pop = m_axis_tvalid && m_axis_tready;

	always_ff @(posedge S_AXIS_ACLK) begin
		if (push)
			fifo_mem[wr_ptr] <= push_res;
	end

	always_ff @(posedge S_AXIS_ACLK) begin
		if (!S_AXIS_ARESETN) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			occupied <= '0;
			reserved <= '0;
		end else begin
			if (push)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			occupied <= occupied + CNT_W'(push) - CNT_W'(pop);
			// Every column read turns into one entry three cycles later
			reserved <= reserved + CNT_W'(rd_en) - CNT_W'(pop);
		end
	end

	// Room for one more whole pass
	assign credit_ok = (int'(reserved) + PASS_LEN) <= `NE_FIFO_DEPTH;

	assign m_axis_tvalid = (occupied != '0);
	assign m_axis_tdata = fifo_mem[rd_ptr].value;
	assign m_axis_tlast = fifo_mem[rd_ptr].last; // End of pass from win_last

endmodule

//--- design/window_sequencer.sv
`timescale 1ns/1ns
`include "net_engine_cfg.svh"

module window_sequencer (
	input logic S_AXIS_ACLK,
	input logic S_AXIS_ARESETN,
	input logic row_done,
	input logic rows_ready,
	input logic credit_ok,
	output logic busy,
	output logic rd_en,
	output logic [$clog2(`NE_ROW_WORDS)-1:0] rd_col,
	output logic rd_last
);

	localparam int COL_W = $clog2(`NE_ROW_WORDS);
	localparam logic [COL_W-1:0] LAST_COL = COL_W'(`NE_ROW_WORDS - 3);

	logic pending; // Row complete, waiting for output room
	logic active;  // Columns being issued

	always_ff @(posedge S_AXIS_ACLK) begin
		if (!S_AXIS_ARESETN) begin
			pending <= 1'b0;
			active <= 1'b0;
			rd_col <= '0;
		end else begin
			if (row_done && rows_ready)
				pending <= 1'b1;

			if (pending && !active && credit_ok) begin
				// Start of pass
				pending <= 1'b0;
				active <= 1'b1;
				rd_col <= '0;
			end else if (active) begin
				if (rd_col == LAST_COL) begin
					active <= 1'b0;
					rd_col <= '0;
				end else begin
					rd_col <= rd_col + 1'b1;
				end
			end
		end
	end

	assign rd_en = active;
	assign rd_last = active && (rd_col == LAST_COL);

	// Drops the cycle after the last column
	assign busy = pending || active;

endmodule

//--- project.f
+incdir+design
design/net_engine_pkg.sv
design/row_buffer_bank.sv
design/window_sequencer.sv
design/conv_cell.sv
design/maxpool_cell.sv
design/stream_source.sv
design/net_engine_top.sv
tests/tb_clock_gen.sv
tests/tb_net_engine.sv

//--- run.sh
#!/bin/sh
# Build and run the net engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_net_engine \
	-f project.f -o sim_net_engine
./obj_dir/sim_net_engine > sim.log 2>&1
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
	exit 1
fi

//--- tests/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
	parameter int PERIOD_NS = 8,
	parameter int RESET_CYCLES = 2
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD_NS / 2) clk = ~clk;
	end

	// Power-on reset, released on a falling edge
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

//--- tests/tb_net_engine.sv
`timescale 1ns/1ns
`include "net_engine_cfg.svh"

module tb_net_engine;
	import net_engine_pkg::*;

	localparam int ROW = `NE_ROW_WORDS;
	localparam int PASS_LEN = `NE_ROW_WORDS - 2;
	localparam int MAX_ROWS = 8;
	localparam int NUM_TESTS = 5;
	localparam int QUIET_CYCLES = 4 * `NE_ROW_WORDS;
	localparam logic [31:0] SEED = 32'h2866729f;

	typedef struct {
		engine_cfg_t cfg;
		int rows;
		int vduty; // Percent of cycles offering s_axis_tvalid
		int rduty; // Percent of cycles with m_axis_tready
		int exp_count;
	} test_entry_t;

	logic clk;
	logic por_n;
	logic entry_rst_n;
	logic dut_rst_n;
	pixel_t s_axis_tdata;
	logic s_axis_tvalid;
	logic s_axis_tready;
	pixel_t m_axis_tdata;
	logic m_axis_tvalid;
	logic m_axis_tready;
	logic m_axis_tlast;
	engine_cfg_t cfg;

	test_entry_t tbl [NUM_TESTS];
	pixel_t img [MAX_ROWS][ROW];
	pixel_t exp_data [$];
	logic exp_last [$];
	logic [31:0] gen_state;
	logic [31:0] drv_state;
	logic [31:0] mon_state;
	logic send_done;
	logic stall_seen;
	int received;
	int wd_cycles;
	int data_errors;
	int last_errors;
	int ctrl_errors;
	int other_errors;

	assign dut_rst_n = por_n && entry_rst_n;

	tb_clock_gen #(.PERIOD_NS(8), .RESET_CYCLES(2)) u_clk (.clk(clk), .rst_n(por_n));

	net_engine_top u_dut (
		.S_AXIS_ACLK(clk), .S_AXIS_ARESETN(dut_rst_n),
		.s_axis_tdata(s_axis_tdata), .s_axis_tvalid(s_axis_tvalid),
		.s_axis_tready(s_axis_tready), .m_axis_tdata(m_axis_tdata),
		.m_axis_tvalid(m_axis_tvalid), .m_axis_tready(m_axis_tready),
		.m_axis_tlast(m_axis_tlast), .cfg(cfg)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function automatic pixel_t next_pixel();
		gen_state = xorshift32(gen_state);
		return pixel_t'(gen_state);
	endfunction

	function automatic test_entry_t make_entry(input logic mode, input int rows,
			input int vduty, input int rduty, input int exp_count);
		test_entry_t t;
		t.cfg = '0;
		t.cfg.mode = mode;
		if (mode) begin
			for (int i = 0; i < `NE_KERNEL_TAPS; i++)
				t.cfg.weight[i] = next_pixel();
			t.cfg.bias = next_pixel();
		end
		t.rows = rows;
		t.vduty = vduty;
		t.rduty = rduty;
		t.exp_count = exp_count;
		return t;
	endfunction

	// Window with its top-left pixel at img[top][col]
	function automatic pixel_t window_result(input engine_cfg_t c, input int top, input int col);
		logic signed [63:0] full;
		pixel_t px;
		pixel_t w;
		pixel_t sum;
		pixel_t best;
		sum = c.bias;
		best = img[top][col];
		for (int i = 0; i < 3; i++) begin
			for (int j = 0; j < 3; j++) begin
				px = img[top + i][col + j];
				w = c.weight[i * 3 + j];
				full = px * w; // Whole product, low word kept below
				sum = sum + pixel_t'(full[31:0]);
				if (px > best)
					best = px;
			end
		end
		return c.mode ? sum : best;
	endfunction

	task automatic build_model(input int e);
		exp_data.delete();
		exp_last.delete();
		for (int r = 0; r < tbl[e].rows; r++)
			for (int c = 0; c < ROW; c++)
				img[r][c] = next_pixel();
		// Every row from the third closes a pass over the three newest rows
		for (int r = 2; r < tbl[e].rows; r++) begin
			for (int c = 0; c < PASS_LEN; c++) begin
				exp_data.push_back(window_result(tbl[e].cfg, r - 2, c));
				exp_last.push_back(c == PASS_LEN - 1);
			end
		end
	endtask

	task automatic check_result(input pixel_t got, input pixel_t exp, input int idx);
		if (got !== exp) begin
			data_errors++;
			$display("Error: m_axis_tdata result %0d got 0x%08h expected 0x%08h", idx, got, exp);
		end
	endtask

	task automatic check_last(input logic got, input logic exp, input int idx);
		if (got !== exp) begin
			last_errors++;
			$display("Error: m_axis_tlast result %0d got 0x%0h expected 0x%0h", idx, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			ctrl_errors++;
			$display("Error: %s got 0x%0h expected 0x%0h", name, got, exp);
		end
	endtask

	task automatic apply_reset(input engine_cfg_t c);
		@(negedge clk);
		entry_rst_n = 1'b0;
		cfg = c;
		s_axis_tvalid = 1'b0;
		m_axis_tready = 1'b0;
		repeat (2) @(negedge clk);
		entry_rst_n = 1'b1;
	endtask

	task automatic send_rows(input int rows, input int vduty);
		int r;
		int c;
		logic taken;
		r = 0;
		c = 0;
		taken = 1'b0;
		while (r < rows) begin
			@(negedge clk);
			if (taken || !s_axis_tvalid) begin // Offered beat holds until taken
				drv_state = xorshift32(drv_state);
				s_axis_tvalid = (drv_state % 100) < 32'(vduty);
			end
			s_axis_tdata = img[r][c];
			taken = s_axis_tvalid && s_axis_tready; // Transfers at the next rising edge
			if (taken) begin
				c = (c == ROW - 1) ? 0 : c + 1;
				if (c == 0)
					r++;
			end
		end
		@(negedge clk);
		s_axis_tvalid = 1'b0;
		send_done = 1'b1;
	endtask

	task automatic receive_results(input int rduty);
		logic rdy;
		while (exp_data.size() > 0) begin
			@(negedge clk);
			mon_state = xorshift32(mon_state);
			rdy = (mon_state % 100) < 32'(rduty);
			m_axis_tready = rdy;
			if (!s_axis_tready && m_axis_tvalid && !rdy)
				stall_seen = 1'b1;
			if (m_axis_tvalid && rdy) begin
				check_result(m_axis_tdata, exp_data.pop_front(), received);
				check_last(m_axis_tlast, exp_last.pop_front(), received);
				received++;
			end
		end
		wait (send_done);
		repeat (QUIET_CYCLES) begin // Anything now is an extra result
			@(negedge clk);
			m_axis_tready = 1'b1;
			if (m_axis_tvalid)
				received++;
		end
	endtask

	initial begin : watchdog
		wait (wd_cycles > 0);
		repeat (wd_cycles) @(posedge clk);
		$display("Timeout: the tests did not finish within %0d cycles", wd_cycles);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin : main
		int total_rows;
		s_axis_tdata = '0;
		s_axis_tvalid = 1'b0;
		m_axis_tready = 1'b0;
		cfg = '0;
		entry_rst_n = 1'b1;
		send_done = 1'b0;
		stall_seen = 1'b0;
		received = 0;
		wd_cycles = 0;
		data_errors = 0;
		last_errors = 0;
		ctrl_errors = 0;
		other_errors = 0;
		gen_state = SEED;
		drv_state = SEED ^ 32'ha5a5a5a5;
		mon_state = SEED ^ 32'h5a5a5a5a;
		// Mode, rows, tvalid duty, tready duty, results expected
		tbl[0] = make_entry(1'b0, 3, 100, 100, 6);
		tbl[1] = make_entry(1'b1, 4, 100, 100, 12);
		tbl[2] = make_entry(1'b0, 7, 70, 60, 30);
		tbl[3] = make_entry(1'b1, 6, 80, 25, 24);
		tbl[4] = make_entry(1'b1, 2, 90, 100, 0); // Too few rows for a pass
		total_rows = 0;
		for (int e = 0; e < NUM_TESTS; e++)
			total_rows += tbl[e].rows;
		wd_cycles = total_rows * ROW * 40;
		wait (por_n);
		for (int e = 0; e < NUM_TESTS; e++) begin
			apply_reset(tbl[e].cfg);
			check_bit("m_axis_tvalid", m_axis_tvalid, 1'b0);
			check_bit("s_axis_tready", s_axis_tready, 1'b1);
			build_model(e);
			send_done = 1'b0;
			stall_seen = 1'b0;
			received = 0;
			fork
				send_rows(tbl[e].rows, tbl[e].vduty);
				receive_results(tbl[e].rduty);
			join
			if (received != tbl[e].exp_count) begin
				other_errors++;
				$display("Entry %0d gave %0d results instead of %0d", e, received, tbl[e].exp_count);
			end
			if (tbl[e].rduty < 50 && !stall_seen) begin
				other_errors++;
				$display("Entry %0d never stalled the input while the output was blocked", e);
			end
		end
		$display("Errors: data %0d, last %0d, control %0d, other %0d",
			data_errors, last_errors, ctrl_errors, other_errors);
		if (data_errors + last_errors + ctrl_errors + other_errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule
